// File: Makefile
# Verilator build and run of the DSP16 front end testbench

VERILATOR ?= verilator
TOP       ?= tb_dsp16
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/dsp16_core.sv
// Core has no DAU and no interrupts, and both memories are expected outside it
`timescale 1ns/1ps
`include "dsp16_macros.svh"

module dsp16_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    output logic [`DSP16_PC_W-1:0]   rom_addr,
    input  logic [`DSP16_DATA_W-1:0] rom_dout,
    output dsp16_pkg::ram_req_t      ram_req,
    input  logic [`DSP16_DATA_W-1:0] ram_rdata
);

    dsp16_pkg::ctrl_t         ctrl;
    logic [`DSP16_DATA_W-1:0] pr_wdata;  // Long value or RAM data for pr

    // Program word to strobes
    dsp16_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .rom_dout (rom_dout),
        .ctrl     (ctrl)
    );

    // Program addressing
    dsp16_xaau u_xaau (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ctrl     (ctrl),
        .pr_wdata (pr_wdata),
        .rom_addr (rom_addr)
    );

    // Data addressing
    dsp16_yaau u_yaau (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ctrl      (ctrl),
        .ram_rdata (ram_rdata),
        .ram_req   (ram_req),
        .pr_wdata  (pr_wdata)
    );

endmodule

// File: logic/dsp16_decode.sv
// Expects rom_dout one enabled cycle behind rom_addr and never decodes branch shadows
`timescale 1ns/1ps
`include "dsp16_macros.svh"

module dsp16_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  logic [`DSP16_DATA_W-1:0] rom_dout,
    output dsp16_pkg::ctrl_t         ctrl
);

    // Words still to be discarded or the data word of a long immediate
    typedef enum logic [1:0] {
        SKIP_NONE = 2'd0,
        SKIP_ONE  = 2'd1,
        SKIP_TWO  = 2'd2,
        SKIP_LONG = 2'd3
    } skip_e;

    skip_e            skip;
    logic             long_y;  // Long immediate goes to the YAAU
    logic             long_x;  // Long immediate goes to pr
    dsp16_pkg::t_op_e op;

    function automatic dsp16_pkg::t_op_e classify(input logic [4:0] t);
        dsp16_pkg::t_op_e res;
        casez (t)
            5'b0000?: res = dsp16_pkg::OP_GOTO_JA;
            5'b1000?: res = dsp16_pkg::OP_CALL_JA;
            5'b11000: res = dsp16_pkg::OP_GOTO_B;
            5'b0001?: res = dsp16_pkg::OP_SHORT_IMM;
            5'b01010: res = dsp16_pkg::OP_LONG_IMM;
            5'b01100: res = dsp16_pkg::OP_RAM_STORE;
            5'b01111: res = dsp16_pkg::OP_RAM_LOAD;
            default:  res = dsp16_pkg::OP_NOP;
        endcase
        return res;
    endfunction

    always_comb begin
        op = classify(rom_dout[15:11]);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl   <= '0;
            skip   <= SKIP_ONE;  // rom_dout is stale in the first cycle
            long_y <= 1'b0;
            long_x <= 1'b0;
        end else if (cen) begin
            ctrl.goto_ja       <= 1'b0;
            ctrl.call_ja       <= 1'b0;
            ctrl.goto_b        <= 1'b0;
            ctrl.short_load    <= 1'b0;
            ctrl.long_load     <= 1'b0;
            ctrl.xaau_imm_load <= 1'b0;
            ctrl.ram_store     <= 1'b0;
            ctrl.ram_load      <= 1'b0;
            ctrl.xaau_ram_load <= 1'b0;

            case (skip)
                SKIP_TWO: skip <= SKIP_ONE;
                SKIP_ONE: skip <= SKIP_NONE;
                SKIP_LONG: begin
                    // Data word while r_field still holds the destination
                    ctrl.imm           <= rom_dout;
                    ctrl.long_load     <= long_y;
                    ctrl.xaau_imm_load <= long_x;
                    skip               <= SKIP_NONE;
                end
                default: begin
                    case (op)
                        dsp16_pkg::OP_GOTO_JA: begin
                            ctrl.goto_ja <= 1'b1;
                            ctrl.i_field <= rom_dout[11:0];
                            skip         <= SKIP_TWO;
                        end
                        dsp16_pkg::OP_CALL_JA: begin
                            ctrl.call_ja <= 1'b1;
                            ctrl.i_field <= rom_dout[11:0];
                            skip         <= SKIP_TWO;
                        end
                        dsp16_pkg::OP_GOTO_B: begin
                            ctrl.goto_b <= 1'b1;
                            skip        <= SKIP_TWO;
                        end
                        dsp16_pkg::OP_SHORT_IMM: begin
                            ctrl.short_load <= 1'b1;
                            ctrl.r_field    <= dsp16_pkg::yreg_e'(rom_dout[11:9] ^ 3'b100);
                            ctrl.imm        <= `DSP16_DATA_W'(rom_dout[8:0]);
                        end
                        dsp16_pkg::OP_LONG_IMM: begin
                            ctrl.r_field <= dsp16_pkg::yreg_e'(rom_dout[6:4]);
                            long_y       <= rom_dout[9:7] == 3'b000;
                            long_x       <= rom_dout[9:7] == 3'b001;  // pr
                            skip         <= SKIP_LONG;
                        end
                        dsp16_pkg::OP_RAM_STORE,
                        dsp16_pkg::OP_RAM_LOAD: begin
                            ctrl.ram_store     <= op == dsp16_pkg::OP_RAM_STORE;
                            ctrl.ram_load      <= op == dsp16_pkg::OP_RAM_LOAD && !rom_dout[10];
                            ctrl.xaau_ram_load <= op == dsp16_pkg::OP_RAM_LOAD && rom_dout[10];
                            ctrl.r_field       <= dsp16_pkg::yreg_e'(rom_dout[6:4]);
                            ctrl.y_field       <= rom_dout[3:2];
                            ctrl.modifier      <= dsp16_pkg::mod_e'(rom_dout[1:0]);
                        end
                        default: ;  // No-op
                    endcase
                end
            endcase
        end
    end

endmodule

// File: logic/dsp16_macros.svh
// Widths are fixed for the 16-bit core and program space is limited to 4K words
`ifndef DSP16_MACROS_SVH
`define DSP16_MACROS_SVH

// Data path and program word width
`define DSP16_DATA_W   16

`define DSP16_PC_W     12  // Program address, 4K words

// RAM address comes straight from a 16-bit pointer
`define DSP16_RAM_AW   16

`define DSP16_RESET_PC 0   // First fetch address after reset

`endif

// File: logic/dsp16_pkg.sv
// Only the T codes named below execute and every other code is a no-op
`include "dsp16_macros.svh"

package dsp16_pkg;

    // T field in bits 15:11 of the program word
    typedef enum logic [4:0] {
        OP_GOTO_JA   = 5'b00000,  // 0000x
        OP_CALL_JA   = 5'b10000,  // 1000x
        OP_GOTO_B    = 5'b11000,  // Return through pr
        OP_SHORT_IMM = 5'b00010,  // 0001x
        OP_NOP       = 5'b01000,  // aT=R and all unused codes
        OP_LONG_IMM  = 5'b01010,
        OP_RAM_STORE = 5'b01100,
        OP_RAM_LOAD  = 5'b01111
    } t_op_e;

    // YAAU register select where codes 6 and 7 select nothing
    typedef enum logic [2:0] {
        R0 = 3'd0,
        R1 = 3'd1,
        R2 = 3'd2,
        R3 = 3'd3,
        J  = 3'd4,
        K  = 3'd5
    } yreg_e;

    // Pointer post-modify
    typedef enum logic [1:0] {
        MOD_NONE  = 2'd0,  // *rN
        MOD_INC   = 2'd1,  // *rN++
        MOD_DEC   = 2'd2,  // *rN--
        MOD_ADD_J = 2'd3   // *rN++j
    } mod_e;

    // Registered decoder output with at most one strobe per cycle
    typedef struct packed {
        logic                     goto_ja;
        logic                     call_ja;
        logic                     goto_b;
        logic                     short_load;     // Short immediate to YAAU
        logic                     long_load;      // Long immediate to YAAU
        logic                     xaau_imm_load;  // Long immediate to pr
        logic                     ram_store;
        logic                     ram_load;       // RAM to YAAU register
        logic                     xaau_ram_load;  // RAM to pr
        yreg_e                    r_field;
        logic [1:0]               y_field;        // Pointer rN
        mod_e                     modifier;
        logic [`DSP16_PC_W-1:0]   i_field;        // Branch target
        logic [`DSP16_DATA_W-1:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic [`DSP16_RAM_AW-1:0] addr;
        logic [`DSP16_DATA_W-1:0] wdata;
        logic                     we;
        logic                     re;
    } ram_req_t;

endpackage

// File: logic/dsp16_xaau.sv
// PC and pr are 12 bits so pr loads keep only the low bits of the data word
`timescale 1ns/1ps
`include "dsp16_macros.svh"

module dsp16_xaau (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp16_pkg::ctrl_t         ctrl,
    input  logic [`DSP16_DATA_W-1:0] pr_wdata,
    output logic [`DSP16_PC_W-1:0]   rom_addr
);

    logic [`DSP16_PC_W-1:0] pc;
    logic [`DSP16_PC_W-1:0] pr;
    logic [`DSP16_PC_W-1:0] pr_fwd;  // pr as seen by a return this cycle
    logic                   pr_ld1;  // RAM read cycle of a load into pr
    logic                   pr_ld2;  // RAM data valid
    logic                   pr_we;

    assign rom_addr = pc;

    // Load data arrives two cycles after the strobe
    assign pr_we  = ctrl.xaau_imm_load | pr_ld2;
    assign pr_fwd = pr_we ? pr_wdata[`DSP16_PC_W-1:0] : pr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= `DSP16_PC_W'(`DSP16_RESET_PC);
            pr     <= '0;
            pr_ld1 <= 1'b0;
            pr_ld2 <= 1'b0;
        end else if (cen) begin
            pr_ld1 <= ctrl.xaau_ram_load;
            pr_ld2 <= pr_ld1;

            // Two words behind the fetch, so pc-1 is the word after the call
            if (ctrl.call_ja)
                pr <= pc - 1'b1;
            else
                pr <= pr_fwd;

            if (ctrl.goto_ja || ctrl.call_ja)
                pc <= ctrl.i_field;
            else if (ctrl.goto_b)
                pc <= pr_fwd;
            else
                pc <= pc + 1'b1;
        end
    end

endmodule

// File: logic/dsp16_yaau.sv
// No rb/re circular buffers and the register right after a load must not read its target
`timescale 1ns/1ps
`include "dsp16_macros.svh"

module dsp16_yaau (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp16_pkg::ctrl_t         ctrl,
    input  logic [`DSP16_DATA_W-1:0] ram_rdata,
    output dsp16_pkg::ram_req_t      ram_req,
    output logic [`DSP16_DATA_W-1:0] pr_wdata
);

    // Register file indexed by yreg_e as r0-r3 then j and k
    logic [5:0][`DSP16_DATA_W-1:0] yr;
    logic [5:0][`DSP16_DATA_W-1:0] yr_fwd;  // With load data merged in
    logic [5:0][`DSP16_DATA_W-1:0] yr_n;

    logic                     ld_pend;  // Load in RAM read cycle
    dsp16_pkg::yreg_e         ld_dst;
    logic                     ld_wb;    // ram_rdata valid
    dsp16_pkg::yreg_e         wb_dst;
    logic                     ram_op;
    logic                     imm_we;
    logic [`DSP16_DATA_W-1:0] ptr;
    logic [`DSP16_DATA_W-1:0] src;
    logic [`DSP16_DATA_W-1:0] step;

    assign ram_op = ctrl.ram_store | ctrl.ram_load | ctrl.xaau_ram_load;
    assign imm_we = ctrl.short_load | ctrl.long_load;

    // Long value wins over a pr load landing the same cycle
    assign pr_wdata = ctrl.xaau_imm_load ? ctrl.imm : ram_rdata;

    always_comb begin
        yr_fwd = yr;
        if (ld_wb && wb_dst <= dsp16_pkg::K)
            yr_fwd[wb_dst] = ram_rdata;
    end

    assign ptr = yr_fwd[ctrl.y_field];
    assign src = (ctrl.r_field <= dsp16_pkg::K) ? yr_fwd[ctrl.r_field] : '0;  // 6, 7 read 0

    always_comb begin
        step = '0;
        case (ctrl.modifier)
            dsp16_pkg::MOD_INC:   step = `DSP16_DATA_W'(1);
            dsp16_pkg::MOD_DEC:   step = '1;  // -1
            dsp16_pkg::MOD_ADD_J: step = yr_fwd[dsp16_pkg::J];
            default:              step = '0;
        endcase
    end

    // Later instruction takes priority over an older load
    always_comb begin
        yr_n = yr_fwd;
        if (ram_op)
            yr_n[ctrl.y_field] = ptr + step;
        if (imm_we && ctrl.r_field <= dsp16_pkg::K)
            yr_n[ctrl.r_field] = ctrl.imm;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            yr      <= '0;
            ram_req <= '0;
            ld_pend <= 1'b0;
            ld_wb   <= 1'b0;
            ld_dst  <= dsp16_pkg::R0;
            wb_dst  <= dsp16_pkg::R0;
        end else if (cen) begin
            yr         <= yr_n;
            ram_req.we <= ctrl.ram_store;
            ram_req.re <= ctrl.ram_load | ctrl.xaau_ram_load;
            if (ram_op) begin
                ram_req.addr  <= ptr[`DSP16_RAM_AW-1:0];  // Address before post-modify
                ram_req.wdata <= src;
            end

            ld_pend <= ctrl.ram_load;
            ld_dst  <= ctrl.r_field;
            ld_wb   <= ld_pend;
            wb_dst  <= ld_dst;
        end
    end

endmodule

// File: sources.f
+incdir+logic
logic/dsp16_pkg.sv
logic/dsp16_decode.sv
logic/dsp16_xaau.sv
logic/dsp16_yaau.sv
logic/dsp16_core.sv
testbench/tb_dsp16.sv

// File: testbench/tb_dsp16.sv
// Programs must end in a goto to itself and every RAM load is followed by a no-op
`timescale 1ns/1ps
`include "dsp16_macros.svh"

module tb_dsp16;

    localparam int          MAX_CYCLES = 4000;  // Per wait loop
    localparam int          STEP_LIMIT = 4000;  // Reference instruction budget
    localparam logic [15:0] NOP        = 16'h4000;
    localparam logic [15:0] MARK       = 16'h605c;  // Store of k through *r3 that must never run

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     cen;
    logic [`DSP16_PC_W-1:0]   rom_addr;
    logic [`DSP16_DATA_W-1:0] rom_dout = '0;
    logic [`DSP16_DATA_W-1:0] ram_rdata = '0;
    dsp16_pkg::ram_req_t      ram_req;

    logic [15:0] rom     [0:4095];
    logic [15:0] ram     [0:65535];
    logic [15:0] ref_ram [0:65535];  // RAM image of the reference model
    logic [31:0] exp_q   [$];        // Expected writes as {addr, data}
    int          pa;                 // Next free ROM address
    int          got = 0;
    int          cmp_err = 0;
    int          cmp_base = 0;
    int          err = 0;
    int          tests = 0;
    int          failed = 0;
    int          total_err = 0;

    always #4 clk = ~clk;

    dsp16_core UUT (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .rom_addr  (rom_addr),
        .rom_dout  (rom_dout),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    // ROM and RAM models
    always @(posedge clk) begin
        if (cen) begin
            rom_dout <= rom[rom_addr];
            if (ram_req.we)
                ram[ram_req.addr] <= ram_req.wdata;
            if (ram_req.re)
                ram_rdata <= ram[ram_req.addr];
        end
    end

    // Write checker sampling what the next edge commits
    always @(negedge clk) begin
        if (rst) begin
            got = 0;
        end else if (cen && ram_req.we) begin
            if (got >= exp_q.size()) begin
                $display("Unexpected extra RAM write of %h to address %h",
                         ram_req.wdata, ram_req.addr);
                cmp_err++;
            end else begin
                if (ram_req.addr !== exp_q[got][31:16]) begin
                    $display("** Error: ram_req.addr = %h, expected %h (write %0d)",
                             ram_req.addr, exp_q[got][31:16], got);
                    cmp_err++;
                end
                if (ram_req.wdata !== exp_q[got][15:0]) begin
                    $display("** Error: ram_req.wdata = %h, expected %h (write %0d)",
                             ram_req.wdata, exp_q[got][15:0], got);
                    cmp_err++;
                end
            end
            got++;
        end
    end

    function automatic logic [15:0] short_word(input int dst, input int val);
        return {4'b0001, 3'(dst) ^ 3'b100, 9'(val)};
    endfunction

    function automatic logic [15:0] ram_word(input bit load, input bit to_pr, input int r,
                                             input int ptr, input int mode);
        logic [4:0] t;
        t = load ? 5'b01111 : 5'b01100;
        return {t, to_pr, 3'b000, 3'(r), 2'(ptr), 2'(mode)};
    endfunction

    function automatic logic [15:0] jump_word(input logic [3:0] t, input int target);
        return {t, 12'(target)};
    endfunction

    task automatic put(input logic [15:0] w);
        rom[pa] = w;
        pa++;
    endtask

    task automatic long_imm(input int grp, input int r, input int val);
        put({5'b01010, 1'b0, 3'(grp), 3'(r), 4'b0000});
        put(16'(val));
    endtask

    task automatic self_loop();
        put(jump_word(4'b0000, pa));
    endtask

    // Instruction level model where branch shadows never execute
    function automatic int ref_model();
        logic [15:0] yr [0:7];  // 6 and 7 stay 0
        logic [11:0] pc;
        logic [11:0] nxt;
        logic [11:0] pr;
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] d;
        logic [15:0] step;
        logic [2:0]  sd;
        exp_q.delete();
        for (int i = 0; i < 8; i++)
            yr[i] = '0;
        pc = 12'(`DSP16_RESET_PC);
        pr = '0;
        for (int n = 0; n < STEP_LIMIT; n++) begin
            w   = rom[pc];
            nxt = pc + 12'd1;
            casez (w[15:11])
                5'b0000?: begin
                    if (w[11:0] == pc)
                        break;  // Program end
                    nxt = w[11:0];
                end
                5'b1000?: begin
                    pr  = pc + 12'd1;
                    nxt = w[11:0];
                end
                5'b11000: nxt = pr;
                5'b0001?: begin
                    sd = w[11:9] ^ 3'b100;
                    if (sd < 3'd6)
                        yr[sd] = {7'd0, w[8:0]};
                end
                5'b01010: begin
                    d = rom[pc + 12'd1];
                    if (w[9:7] == 3'b000 && w[6:4] < 3'd6)
                        yr[w[6:4]] = d;
                    if (w[9:7] == 3'b001)
                        pr = d[11:0];
                    nxt = pc + 12'd2;  // Data word is not an instruction
                end
                5'b01100, 5'b01111: begin
                    a = yr[{1'b0, w[3:2]}];
                    d = yr[w[6:4]];
                    case (w[1:0])
                        2'd1:    step = 16'd1;
                        2'd2:    step = 16'hffff;
                        2'd3:    step = yr[4];  // j
                        default: step = 16'd0;
                    endcase
                    yr[{1'b0, w[3:2]}] = a + step;
                    if (!w[11]) begin
                        ref_ram[a] = d;
                        exp_q.push_back({a, d});
                    end else if (w[10]) begin
                        pr = ref_ram[a][11:0];
                    end else if (w[6:4] < 3'd6) begin
                        yr[w[6:4]] = ref_ram[a];
                    end
                end
                default: ;
            endcase
            pc = nxt;
        end
        return exp_q.size();
    endfunction

    // Holds reset while both memories are refilled
    task automatic setup_memories();
        @(posedge clk);
        rst <= 1'b1;
        cen <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 4096; i++)
            rom[i] = NOP;
        for (int i = 0; i < 65536; i++) begin
            ram[i]     = {i[7:0], i[15:8]} ^ 16'h5a3c;
            ref_ram[i] = {i[7:0], i[15:8]} ^ 16'h5a3c;
        end
        exp_q.delete();
        pa       = 0;
        err      = 0;
        cmp_base = cmp_err;
    endtask

    task automatic report(input string name, input int n_exp);
        err += cmp_err - cmp_base;
        tests++;
        total_err += err;
        if (err != 0)
            failed++;
        $display("Test %0d %s: %0d writes %s", tests, name, n_exp, err != 0 ? "FAILED" : "ok");
    endtask

    task automatic run_program(input string name, input bit rand_cen);
        int n_exp;
        int cyc;
        n_exp = ref_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cyc = 0;
        while (got < n_exp && cyc < MAX_CYCLES) begin
            @(posedge clk);
            cen <= rand_cen ? ($urandom_range(3) != 0) : 1'b1;
            cyc++;
        end
        if (got < n_exp) begin
            $display("Test %s timed out with %0d of %0d RAM writes seen", name, got, n_exp);
            err++;
        end
        @(posedge clk);
        cen <= 1'b1;
        repeat (40) @(posedge clk);  // Let any stray write show up
        report(name, n_exp);
    endtask

    initial begin
        rst = 1'b1;
        cen = 1'b1;
        void'($urandom(49606));

        // Idle ROM, PC counts and no RAM traffic
        setup_memories();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 24; i++) begin
            @(negedge clk);
            if (rom_addr !== 12'(i)) begin
                $display("** Error: rom_addr = %h, expected %h", rom_addr, 12'(i));
                err++;
            end
            if (ram_req.re !== 1'b0) begin
                $display("** Error: ram_req.re = %h, expected 0", ram_req.re);
                err++;
            end
        end
        report("idle", 0);

        setup_memories();
        for (int d = 1; d < 8; d++)
            put(short_word(d, d * 37 + 5));
        put(short_word(0, 9'h100));
        for (int d = 0; d < 8; d++)
            put(ram_word(1'b0, 1'b0, d, 0, 1));
        self_loop();
        run_program("short immediates", 1'b0);

        setup_memories();
        long_imm(0, 0, 16'h1200);
        long_imm(0, 1, 16'h2400);
        long_imm(0, 2, 16'h3600);
        long_imm(0, 3, 16'hfff0);  // Wraps under ++j
        long_imm(0, 4, 16'h0013);  // j
        long_imm(0, 5, 16'hbeef);
        for (int m = 0; m < 4; m++)
            for (int p = 0; p < 4; p++) begin
                put(ram_word(1'b0, 1'b0, (m + p) % 6, p, m));
                put(ram_word(1'b0, 1'b0, 5, p, m));
            end
        self_loop();
        run_program("long and modes", 1'b0);

        // Markers fill the shadows of the goto and the return
        setup_memories();
        put(short_word(0, 9'h040));
        put(short_word(5, 9'h011));
        put(jump_word(4'b0000, 8));
        for (int i = 0; i < 5; i++)
            put(MARK);
        put(ram_word(1'b0, 1'b0, 5, 0, 1));
        put(jump_word(4'b1000, 20));  // Returns to 10
        put(ram_word(1'b0, 1'b0, 0, 0, 1));
        self_loop();
        pa = 20;
        put(short_word(1, 9'h055));
        put(ram_word(1'b0, 1'b0, 1, 0, 1));
        put(16'hc000);
        put(MARK);
        put(MARK);
        run_program("branches", 1'b0);

        setup_memories();
        put(short_word(0, 9'h080));
        put(short_word(1, 9'h090));
        put(short_word(2, 9'h0a0));
        put(ram_word(1'b1, 1'b0, 3, 0, 1));
        put(NOP);
        put(ram_word(1'b0, 1'b0, 3, 2, 1));
        put(ram_word(1'b1, 1'b0, 4, 0, 0));  // Load j
        put(NOP);
        put(ram_word(1'b0, 1'b0, 3, 0, 3));
        put(short_word(3, 9'h1c0));
        put(ram_word(1'b0, 1'b0, 3, 1, 0));  // Return address into RAM
        put(ram_word(1'b1, 1'b1, 0, 1, 1));  // and back into pr
        put(NOP);
        put(16'hc000);
        put(MARK);
        put(MARK);
        pa = 12'h1c0;
        put(ram_word(1'b0, 1'b0, 4, 2, 1));
        put(ram_word(1'b0, 1'b0, 0, 2, 1));
        self_loop();
        run_program("ram loads", 1'b0);

        setup_memories();
        for (int r = 0; r < 4; r++)
            long_imm(0, r, $urandom);
        put(short_word(4, $urandom_range(15)));
        for (int n = 0; n < 60; n++) begin
            case ($urandom_range(5))
                0: put(short_word($urandom_range(7), $urandom_range(511)));
                1: long_imm(0, $urandom_range(7), $urandom);
                2, 3: put(ram_word(1'b0, 1'b0, $urandom_range(7), $urandom_range(3),
                                   $urandom_range(3)));
                4: begin
                    put(ram_word(1'b1, 1'b0, $urandom_range(7), $urandom_range(3),
                                 $urandom_range(3)));
                    put(NOP);
                end
                default: begin
                    put(jump_word(4'b0000, pa + 3));
                    put(MARK);
                    put(MARK);
                end
            endcase
        end
        self_loop();
        run_program("random with cen", 1'b1);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, total_err);
        if (failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
